// ==== source/div_pkg.sv ====
package div_pkg;

    // ****************************************
    // widths
    // ****************************************

    localparam int data_width  = 32;
    localparam int count_width = 6;    // holds 0 to 32

    typedef logic [data_width-1:0]  word_t;
    typedef logic [count_width-1:0] count_t;

    // ****************************************
    // operands, plan and result
    // ****************************************

    typedef struct packed {
        word_t dividend;
        word_t divisor;
    } div_cmd_t;

    typedef struct packed {
        count_t shift;         // leading zeros of the dividend
        count_t iterations;    // shift-subtract steps still needed
        logic   by_zero;
    } div_plan_t;

    typedef struct packed {
        word_t quotient;
        word_t remainder;
    } div_result_t;

    // ****************************************
    // core sequencer
    // ****************************************

    typedef enum logic [1:0] {
        idle,
        load,       // pre-shift and counter load
        iterate,
        finish      // result valid, done pulse
    } seq_state_t;

endpackage

// ==== source/wb_pkg.sv ====
package wb_pkg;

    import div_pkg::*;

    localparam int addr_width = 5;

    typedef logic [addr_width-1:0] wb_addr_t;    // byte address

    // classic cycle, master side
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        wb_addr_t   adr;
        word_t      dat;
        logic [3:0] sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    // ****************************************
    // register map
    // ****************************************

    localparam wb_addr_t addr_dividend  = 5'h00;
    localparam wb_addr_t addr_divisor   = 5'h04;    // write starts a division
    localparam wb_addr_t addr_quotient  = 5'h08;
    localparam wb_addr_t addr_remainder = 5'h0C;
    localparam wb_addr_t addr_status    = 5'h10;

    // status word bits
    localparam int status_busy    = 0;
    localparam int status_done    = 1;    // sticky until next start
    localparam int status_by_zero = 2;

endpackage

// ==== source/div_operand_check.sv ====
`timescale 1ns/1ps

module div_operand_check import div_pkg::*; (
    input  div_cmd_t  cmd,
    output div_plan_t plan
);

    count_t lead_zeros;
    count_t steps;
    logic   divisor_zero;

    // ****************************************
    // leading zero count
    // ****************************************

    // scan upward so the highest set bit wins
    always_comb begin
        lead_zeros = count_t'(data_width);    // zero dividend
        for (int i = 0; i < data_width; i++) begin
            if (cmd.dividend[i]) begin
                lead_zeros = count_t'(data_width - 1 - i);
            end
        end
    end

    // one step per significant dividend bit
    assign steps = count_t'(data_width) - lead_zeros;

    // ****************************************
    // divisor check
    // ****************************************

    assign divisor_zero = (cmd.divisor == '0);

    // ****************************************
    // plan
    // ****************************************

    always_comb begin
        plan.shift   = lead_zeros;
        plan.by_zero = divisor_zero;
        if (divisor_zero) begin
            plan.iterations = '0;    // core skips straight to finish
        end else begin
            plan.iterations = steps;
        end
    end

endmodule

// ==== source/div_restoring_core.sv ====
`timescale 1ns/1ps

module div_restoring_core import div_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  div_cmd_t    cmd,
    input  div_plan_t   plan,
    output logic        busy,
    output logic        done,
    output div_result_t result
);

    seq_state_t          state;
    seq_state_t          state_next;
    count_t              count;
    div_cmd_t            cmd_q;
    div_plan_t           plan_q;
    word_t               rem_q;
    word_t               quo_q;
    logic [data_width:0] shifted;
    logic [data_width:0] diff;
    word_t               rem_next;
    word_t               quo_next;

    // ****************************************
    // sequencer
    // ****************************************

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (start) begin
                    state_next = load;
                end
            end
            load: begin
                if (plan_q.iterations == '0) begin
                    state_next = finish;    // by zero or zero dividend
                end else begin
                    state_next = iterate;
                end
            end
            iterate: begin
                if (count == count_t'(1)) begin
                    state_next = finish;
                end
            end
            finish: begin
                state_next = idle;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= idle;
            count <= '0;
        end else begin
            state <= state_next;
            case (state)
                load:    count <= plan_q.iterations;
                iterate: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ****************************************
    // shift-subtract step
    // ****************************************

    // partial remainder stays below the divisor, so one guard bit is enough
    always_comb begin
        shifted  = {rem_q, quo_q[data_width-1]};
        diff     = shifted - {1'b0, cmd_q.divisor};
        quo_next = {quo_q[data_width-2:0], ~diff[data_width]};
        if (diff[data_width]) begin
            rem_next = shifted[data_width-1:0];    // restore
        end else begin
            rem_next = diff[data_width-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            cmd_q  <= cmd;
            plan_q <= plan;
        end
        case (state)
            load: begin
                if (plan_q.by_zero) begin
                    quo_q <= '1;
                    rem_q <= cmd_q.dividend;
                end else begin
                    quo_q <= cmd_q.dividend << plan_q.shift;    // skip leading zeros
                    rem_q <= '0;
                end
            end
            iterate: begin
                quo_q <= quo_next;
                rem_q <= rem_next;
            end
            default: begin
                quo_q <= quo_q;
                rem_q <= rem_q;
            end
        endcase
    end

    // ****************************************
    // outputs
    // ****************************************

    assign busy             = (state == load) || (state == iterate);
    assign done             = (state == finish);
    assign result.quotient  = quo_q;
    assign result.remainder = rem_q;

endmodule

// ==== source/wb_div_regs.sv ====
`timescale 1ns/1ps

module wb_div_regs import div_pkg::*, wb_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  wb_req_t     wb_req,
    output wb_rsp_t     wb_rsp,
    output div_cmd_t    cmd,
    output logic        start,
    input  div_plan_t   plan,
    input  logic        busy,
    input  logic        done,
    input  div_result_t result
);

    logic        ack_q;
    logic        req;
    logic        wr;
    logic        start_q;
    word_t       dividend_q;
    word_t       divisor_q;
    div_result_t result_q;
    logic        done_q;
    logic        by_zero_q;
    word_t       status;
    word_t       rd_data;

    // ****************************************
    // bus handshake
    // ****************************************

    assign req = wb_req.cyc && wb_req.stb && !ack_q;    // new access
    assign wr  = req && wb_req.we;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ack_q   <= 1'b0;
            start_q <= 1'b0;
        end else begin
            ack_q   <= req;
            start_q <= wr && (wb_req.adr == addr_divisor) && !busy;    // lands on the ack
        end
    end

    // ****************************************
    // operand registers
    // ****************************************

    // full word writes, sel not decoded
    always_ff @(posedge clk) begin
        if (wr && wb_req.adr == addr_dividend) begin
            dividend_q <= wb_req.dat;
        end
        if (wr && wb_req.adr == addr_divisor && !busy) begin
            divisor_q <= wb_req.dat;    // held while a division runs
        end
    end

    // ****************************************
    // result and status
    // ****************************************

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            result_q  <= '0;
            by_zero_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            if (done) begin
                result_q  <= result;
                by_zero_q <= plan.by_zero;
            end
            if (start_q) begin
                done_q <= 1'b0;
            end else if (done) begin
                done_q <= 1'b1;
            end
        end
    end

    always_comb begin
        status                 = '0;
        status[status_busy]    = busy;
        status[status_done]    = done_q;
        status[status_by_zero] = by_zero_q;
    end

    // address still held by the master during ack
    always_comb begin
        case (wb_req.adr)
            addr_dividend:  rd_data = dividend_q;
            addr_divisor:   rd_data = divisor_q;
            addr_quotient:  rd_data = result_q.quotient;
            addr_remainder: rd_data = result_q.remainder;
            addr_status:    rd_data = status;
            default:        rd_data = '0;
        endcase
    end

    assign cmd.dividend = dividend_q;
    assign cmd.divisor  = divisor_q;
    assign start        = start_q;
    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat   = rd_data;

endmodule

// ==== source/wb_divider_top.sv ====
`timescale 1ns/1ps

module wb_divider_top import div_pkg::*, wb_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    div_cmd_t    cmd;
    div_plan_t   plan;
    div_result_t result;
    logic        start;
    logic        busy;
    logic        done;

    wb_div_regs i_regs (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .cmd    (cmd),
        .start  (start),
        .plan   (plan),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    // same operands feed checker and core
    div_operand_check i_check (
        .cmd  (cmd),
        .plan (plan)
    );

    div_restoring_core i_core (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .cmd    (cmd),
        .plan   (plan),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

endmodule

// ==== verif/tb_wb_divider.sv ====
`timescale 1ns/1ps

module tb_wb_divider import div_pkg::*, wb_pkg::*; ();

    localparam int clk_period          = 4;
    localparam int reset_cycles        = 8;
    localparam int ack_limit           = 16;
    localparam int poll_limit          = 50;
    localparam int num_divisions       = 100;
    localparam int cycles_per_division = 100;
    localparam int margin_cycles       = 2000;
    localparam int watchdog_cycles     = reset_cycles
                                       + num_divisions * cycles_per_division
                                       + margin_cycles;

    logic    clk;
    logic    reset;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    integer  seed;
    int      error_count;
    int      check_count;
    word_t   last_quotient;

    wb_divider_top i_dut (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #(clk_period / 2) clk = ~clk;

    // ****************************************
    // bus and checking tasks
    // ****************************************

    task automatic check_word(input string what, input word_t got, input word_t exp);
        check_count++;
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s got 0x%08h, expected 0x%08h", $time, what, got, exp);
            error_count++;
        end
    endtask

    // one classic cycle, ack expected one edge after the request
    task automatic bus_access(input logic we, input wb_addr_t addr, input word_t wdata,
                              output word_t rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = addr;
        wb_req.dat = wdata;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_rsp.ack && waited < ack_limit);
        if (!wb_rsp.ack) begin
            $display("bus timeout: no ack for address 0x%02h after %0d cycles", addr, waited);
            error_count++;
        end else begin
            rdata = wb_rsp.dat;    // sampled while ack is high
            check_word($sformatf("ack delay at 0x%02h", addr), word_t'(waited), 32'd1);
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        @(posedge clk);
        #1;
        check_word($sformatf("ack after access at 0x%02h", addr), word_t'(wb_rsp.ack), '0);
    endtask

    task automatic wb_write(input wb_addr_t addr, input word_t data);
        word_t unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input wb_addr_t addr, output word_t data);
        bus_access(1'b0, addr, '0, data);
    endtask

    task automatic wait_done(output logic ok);
        word_t st;
        int    polls;
        ok    = 1'b0;
        polls = 0;
        while (!ok && polls < poll_limit) begin
            wb_read(addr_status, st);
            polls++;
            ok = st[status_done];
        end
        if (!ok) begin
            $display("poll timeout: status done bit still clear after %0d reads", polls);
            error_count++;
        end
    endtask

    task automatic run_div(input word_t dividend, input word_t divisor, output logic ok);
        wb_write(addr_dividend, dividend);
        wb_write(addr_divisor, divisor);    // starts the division
        wait_done(ok);
    endtask

    task automatic check_division(input word_t dividend, input word_t divisor);
        word_t exp_q;
        word_t exp_r;
        word_t exp_st;
        word_t got;
        logic  ok;
        if (divisor == '0) begin
            exp_q = '1;
            exp_r = dividend;
        end else begin
            exp_q = dividend / divisor;
            exp_r = dividend % divisor;
        end
        exp_st                 = '0;
        exp_st[status_done]    = 1'b1;
        exp_st[status_by_zero] = (divisor == '0);
        run_div(dividend, divisor, ok);
        if (ok) begin
            wb_read(addr_quotient, got);
            check_word($sformatf("quotient of 0x%08h / 0x%08h", dividend, divisor), got, exp_q);
            wb_read(addr_remainder, got);
            check_word($sformatf("remainder of 0x%08h / 0x%08h", dividend, divisor), got, exp_r);
            wb_read(addr_status, got);
            check_word($sformatf("status after 0x%08h / 0x%08h", dividend, divisor), got, exp_st);
        end
        last_quotient = exp_q;
    endtask

    // ****************************************
    // tests
    // ****************************************

    task automatic test_reset_state();
        word_t got;
        wb_read(addr_status, got);
        check_word("status after reset", got, '0);
        wb_read(addr_quotient, got);
        check_word("quotient after reset", got, '0);
        wb_read(addr_remainder, got);
        check_word("remainder after reset", got, '0);
    endtask

    task automatic test_directed();
        check_division(32'd100, 32'd7);
        check_division(32'hffff_ffff, 32'd1);
        check_division(32'd5, 32'd9);    // quotient 0
        check_division(32'd0, 32'd3);
        check_division(32'hffff_ffff, 32'hffff_ffff);
    endtask

    task automatic test_by_zero();
        check_division(32'd12345, 32'd0);
        check_division(32'hffff_ffff, 32'd0);
        check_division(32'd0, 32'd0);
    endtask

    task automatic test_random();
        word_t dividend;
        word_t divisor;
        for (int i = 0; i < 80; i++) begin
            dividend = $random(seed);
            divisor  = $random(seed);
            case (i % 4)
                0: divisor = divisor & 32'h0000_00ff;    // small divisors, zero possible
                1: divisor = divisor & 32'h0000_000f;
                2: dividend = dividend & 32'h0000_ffff;  // shorter latency
                default: ;
            endcase
            check_division(dividend, divisor);
        end
    endtask

    task automatic test_busy_write();
        word_t prev_q;
        word_t got;
        logic  ok;
        prev_q = last_quotient;
        wb_write(addr_dividend, 32'hdead_beef);
        wb_write(addr_divisor, 32'd13);
        wb_write(addr_divisor, 32'd5);    // core busy, must be dropped
        wb_read(addr_status, got);
        check_word("busy bit during division", word_t'(got[status_busy]), 32'd1);
        wb_read(addr_quotient, got);
        check_word("quotient read while busy", got, prev_q);
        wait_done(ok);
        if (ok) begin
            wb_read(addr_quotient, got);
            check_word("quotient after ignored write", got, 32'hdead_beef / 32'd13);
            wb_read(addr_remainder, got);
            check_word("remainder after ignored write", got, 32'hdead_beef % 32'd13);
        end
        wb_read(addr_divisor, got);
        check_word("divisor readback", got, 32'd13);
        wb_write(5'h1C, 32'h1234_5678);    // unmapped
        wb_read(5'h1C, got);
        check_word("unmapped 0x1c read", got, '0);
        wb_read(5'h14, got);
        check_word("unmapped 0x14 read", got, '0);
        wb_read(addr_dividend, got);
        check_word("dividend readback", got, 32'hdead_beef);
    endtask

    // ****************************************
    // main sequence and watchdog
    // ****************************************

    initial begin
        clk           = 1'b0;
        reset         = 1'b0;
        wb_req        = '0;
        wb_req.sel    = 4'hf;
        seed          = 32'hf5a1;
        error_count   = 0;
        check_count   = 0;
        last_quotient = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b1;
        test_reset_state();
        test_directed();
        test_by_zero();
        test_random();
        test_busy_write();
        $display("errors: %0d of %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("test failed");
        $finish;
    end

endmodule

// ==== all.f ====
source/div_pkg.sv
source/wb_pkg.sv
source/div_operand_check.sv
source/div_restoring_core.sv
source/wb_div_regs.sv
source/wb_divider_top.sv
verif/tb_wb_divider.sv

// ==== Bender.yml ====
package:
  name: wb_divider

sources:
  - files:
      - source/div_pkg.sv
      - source/wb_pkg.sv
      - source/div_operand_check.sv
      - source/div_restoring_core.sv
      - source/wb_div_regs.sv
      - source/wb_divider_top.sv
  - target: test
    files:
      - verif/tb_wb_divider.sv
